//--- bench/sdram_model.sv
// Behavioral x16 SDR SDRAM with command decode, full-page bursts and CAS latency 3
`default_nettype none

module sdram_model
(
	input  wire                  clk,
	input  wire                  cke,
	input  wire                  cs_n,
	input  wire                  ras_n,
	input  wire                  cas_n,
	input  wire                  we_n,
	input  wire sdram_pkg::ba_t  ba,
	input  wire sdram_pkg::row_t addr,
	input  wire [1:0]            dqm,
	inout  wire sdram_pkg::dq_t  dq
);
	timeunit 1ns;
	timeprecision 1ps;
	import sdram_pkg::*;

	dq_t        mem [app_addr_t];   // Sparse storage
	row_t       open_row [4];       // Row held by each bank
	sdram_cmd_e cmd;
	logic       wr_act;             // Write burst running
	logic       rd_act;             // Read burst running
	ba_t        wr_ba;
	ba_t        rd_ba;
	col_t       wr_col;             // Next write column
	col_t       rd_col;             // Next read column
	logic       pipe_v [2];         // CAS latency line
	app_addr_t  pipe_a [2];
	logic       drv_en;
	dq_t        drv_data;

	assign cmd = (cke && !cs_n) ? sdram_cmd_e'({ras_n, cas_n, we_n}) : NOP;
	assign dq  = drv_en ? drv_data : 'z;

	// Unwritten words come from an address-derived pattern
	function automatic dq_t fetch(input app_addr_t a);
		if (mem.exists(a))
			return mem[a];
		return dq_t'(a ^ (a >> 8));
	endfunction

	// Bytes under DQM keep their stored value
	task automatic store(input app_addr_t a, input dq_t d);
		dq_t w;
		w = fetch(a);
		if (!dqm[0])
			w[7:0] = d[7:0];
		if (!dqm[1])
			w[15:8] = d[15:8];
		mem[a] = w;
	endtask

	initial
	begin
		wr_act    = 1'b0;
		rd_act    = 1'b0;
		pipe_v[0] = 1'b0;
		pipe_v[1] = 1'b0;
		drv_en    = 1'b0;
	end

	// ------------------------------------------------------------------------
	// Command decode, one beat per clock while a burst runs
	// ------------------------------------------------------------------------
	always @(posedge clk)
	begin
		pipe_v[1] <= pipe_v[0];
		pipe_a[1] <= pipe_a[0];
		drv_en    <= pipe_v[1];         // Word on DQ three edges after READ
		drv_data  <= fetch(pipe_a[1]);
		pipe_v[0] <= 1'b0;
		case (cmd)
			ACT:
				open_row[ba] <= addr;
			READ:
			begin
				rd_act    <= 1'b1;
				wr_act    <= 1'b0;
				rd_ba     <= ba;
				rd_col    <= addr[8:0] + 1'b1;
				pipe_v[0] <= 1'b1;
				pipe_a[0] <= {ba, open_row[ba], addr[8:0]};
			end
			WRITE:
			begin
				store({ba, open_row[ba], addr[8:0]}, dq);  // First word with command
				wr_act <= 1'b1;
				rd_act <= 1'b0;
				wr_ba  <= ba;
				wr_col <= addr[8:0] + 1'b1;
			end
			BST, PRE:
			begin
				rd_act <= 1'b0;                 // Burst terminate
				wr_act <= 1'b0;
			end
			default:
			begin
				if (rd_act)
				begin
					pipe_v[0] <= 1'b1;
					pipe_a[0] <= {rd_ba, open_row[rd_ba], rd_col};
					rd_col    <= rd_col + 1'b1;     // Wraps inside the page
				end
				else if (wr_act)
				begin
					store({wr_ba, open_row[wr_ba], wr_col}, dq);
					wr_col <= wr_col + 1'b1;
				end
			end
		endcase
	end

endmodule

`default_nettype wire

//--- bench/tb_sdram_ctrl.sv
// Directed testbench for the SDR SDRAM controller against a behavioral device
`default_nettype none

module tb_sdram_ctrl;
	timeunit 1ns;
	timeprecision 1ps;
	import sdram_pkg::*;

	logic       clk;
	logic       rst;
	logic       wr_burst_req;
	dq_t        wr_burst_data;
	burst_len_t wr_burst_len;
	app_addr_t  wr_burst_addr;
	logic       rd_burst_req;
	burst_len_t rd_burst_len;
	app_addr_t  rd_burst_addr;
	wire        wr_burst_data_req;
	wire        wr_burst_finish;
	wire dq_t   rd_burst_data;
	wire        rd_burst_data_valid;
	wire        rd_burst_finish;
	wire        sdram_cke;
	wire        sdram_cs_n;
	wire        sdram_ras_n;
	wire        sdram_cas_n;
	wire        sdram_we_n;
	wire ba_t   sdram_ba;
	wire row_t  sdram_addr;
	wire [1:0]  sdram_dqm;
	wire dq_t   sdram_dq;

	integer     seed = 54893;
	integer     errors = 0;
	integer     checks = 0;
	integer     cyc = 0;            // Clock count
	integer     n_ref = 0;          // REF commands seen
	integer     ref_prev = 0;
	integer     ref_last = 0;
	integer     req_cnt = 0;
	integer     wfin_cnt = 0;
	integer     vld_cnt = 0;
	integer     rfin_cnt = 0;
	integer     wr_idx = 0;
	sdram_cmd_e cmd_log [$];        // Non-NOP commands on the pins
	ba_t        ba_log [$];
	row_t       addr_log [$];
	dq_t        wr_buf [0:511];     // Words of the running write
	dq_t        exp_q [$];          // Words still expected from a read
	dq_t        sb [app_addr_t];    // Scoreboard of written words
	sdram_cmd_e pin_cmd;

	assign pin_cmd = sdram_cmd_e'({sdram_ras_n, sdram_cas_n, sdram_we_n});

	sdram_ctrl_top u_sdram_ctrl_top (
		.clk (clk), .rst (rst),
		.wr_burst_req (wr_burst_req), .wr_burst_data (wr_burst_data),
		.wr_burst_len (wr_burst_len), .wr_burst_addr (wr_burst_addr),
		.wr_burst_data_req (wr_burst_data_req), .wr_burst_finish (wr_burst_finish),
		.rd_burst_req (rd_burst_req), .rd_burst_len (rd_burst_len),
		.rd_burst_addr (rd_burst_addr), .rd_burst_data (rd_burst_data),
		.rd_burst_data_valid (rd_burst_data_valid), .rd_burst_finish (rd_burst_finish),
		.sdram_cke (sdram_cke), .sdram_cs_n (sdram_cs_n), .sdram_ras_n (sdram_ras_n),
		.sdram_cas_n (sdram_cas_n), .sdram_we_n (sdram_we_n), .sdram_ba (sdram_ba),
		.sdram_addr (sdram_addr), .sdram_dqm (sdram_dqm), .sdram_dq (sdram_dq)
	);

	sdram_model u_model (
		.clk (clk), .cke (sdram_cke), .cs_n (sdram_cs_n), .ras_n (sdram_ras_n),
		.cas_n (sdram_cas_n), .we_n (sdram_we_n), .ba (sdram_ba), .addr (sdram_addr),
		.dqm (sdram_dqm), .dq (sdram_dq)
	);

	initial
		clk = 1'b0;
	always #20 clk = ~clk;          // 40 ns period

	// ------------------------------------------------------------------------
	// Compare helpers
	// ------------------------------------------------------------------------
	task automatic check_dq(input string name, input dq_t got, input dq_t exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic check_cmd(input string name, input sdram_cmd_e got, input sdram_cmd_e exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("FAIL %s got 0x%h (%s) expected 0x%h (%s)", name, got, got.name(),
				exp, exp.name());
		end
	endtask

	task automatic check_count(input string name, input integer got, input integer exp);
		checks = checks + 1;
		if (got !== exp)
		begin
			errors = errors + 1;
			$display("FAIL %s got 0x%h expected 0x%h", name, got, exp);
		end
	endtask

	task automatic print_summary();
		$display("Checks run %0d, errors %0d", checks, errors);
	endtask

	task automatic abort_timeout(input string what);
		$display("Timed out waiting for %s", what);
		print_summary();
		$display("Testbench failed");
		$finish;
	endtask

	// ------------------------------------------------------------------------
	// Pin monitor, strobe counters and read checker
	// ------------------------------------------------------------------------
	always @(posedge clk)
	begin
		cyc = cyc + 1;
		if (!rst && (pin_cmd != NOP))
		begin
			cmd_log.push_back(pin_cmd);
			ba_log.push_back(sdram_ba);
			addr_log.push_back(sdram_addr);
		end
		if (!rst && (pin_cmd == REF))
		begin
			ref_prev = ref_last;
			ref_last = cyc;
			n_ref    = n_ref + 1;
		end
		if (wr_burst_data_req)
			req_cnt = req_cnt + 1;
		if (wr_burst_finish)
			wfin_cnt = wfin_cnt + 1;
		if (rd_burst_finish)
			rfin_cnt = rfin_cnt + 1;
		if (rd_burst_data_valid)
		begin
			vld_cnt = vld_cnt + 1;
			if (exp_q.size() == 0)
			begin
				errors = errors + 1;
				$display("Read data valid with no word expected");
			end
			else
				check_dq("rd_burst_data", rd_burst_data, exp_q.pop_front());
		end
	end

	// Next write word on the cycle after each request
	always @(posedge clk)
	begin
		if (wr_burst_data_req)
		begin
			wr_burst_data <= wr_buf[wr_idx];
			wr_idx = wr_idx + 1;
		end
	end

	function automatic app_addr_t rand_addr();
		return app_addr_t'($random(seed));
	endfunction

	function automatic integer rand_len();
		return ($random(seed) & 32'h1ff) + 1;     // 1 to 512
	endfunction

	// ------------------------------------------------------------------------
	// Burst access tasks
	// ------------------------------------------------------------------------
	task automatic run_write(input app_addr_t a, input integer len);
		integer    n;
		app_addr_t k;
		for (n = 0; n < len; n = n + 1)
		begin
			wr_buf[n] = dq_t'($random(seed));
			k         = a;
			k.col     = a.col + n;          // Column wraps in the page
			sb[k]     = wr_buf[n];
		end
		wr_idx   = 0;
		req_cnt  = 0;
		wfin_cnt = 0;
		@(posedge clk);
		wr_burst_addr <= a;
		wr_burst_len  <= len;
		wr_burst_req  <= 1'b1;
		@(posedge clk);
		n = 0;
		while (!wr_burst_finish && (n < 4000))
		begin
			@(posedge clk);
			n = n + 1;
		end
		if (n >= 4000)
			abort_timeout("wr_burst_finish");
		else
		begin
			wr_burst_req <= 1'b0;
			@(posedge clk);
			@(posedge clk);
			check_count("wr_burst_data_req pulses", req_cnt, len);
			check_count("wr_burst_finish pulses", wfin_cnt, 1);
		end
	endtask

	task automatic run_read(input app_addr_t a, input integer len);
		integer    n;
		app_addr_t k;
		for (n = 0; n < len; n = n + 1)
		begin
			k     = a;
			k.col = a.col + n;
			exp_q.push_back(sb[k]);
		end
		vld_cnt  = 0;
		rfin_cnt = 0;
		@(posedge clk);
		rd_burst_addr <= a;
		rd_burst_len  <= len;
		rd_burst_req  <= 1'b1;
		@(posedge clk);
		n = 0;
		while (!rd_burst_finish && (n < 4000))
		begin
			@(posedge clk);
			n = n + 1;
		end
		if (n >= 4000)
			abort_timeout("rd_burst_finish");
		else
		begin
			rd_burst_req <= 1'b0;
			@(posedge clk);
			@(posedge clk);
			check_count("rd_burst_data_valid cycles", vld_cnt, len);
			check_count("rd_burst_finish pulses", rfin_cnt, 1);
			check_count("read words not returned", exp_q.size(), 0);
			exp_q.delete();
		end
	endtask

	// Fields of the first ACT after start and the column command behind it
	task automatic check_access(input integer start, input app_addr_t a, input sdram_cmd_e exp);
		integer i;
		i = start;
		while ((i < cmd_log.size()) && (cmd_log[i] != ACT))
			i = i + 1;
		if (i + 1 >= cmd_log.size())
		begin
			errors = errors + 1;
			$display("No ACT followed by a column command was seen for the access");
		end
		else
		begin
			check_count("sdram_ba on ACT", ba_log[i], a.ba);
			check_count("sdram_addr on ACT", addr_log[i], a.row);
			check_cmd("command after ACT", cmd_log[i + 1], exp);
			check_count("sdram_ba on column command", ba_log[i + 1], a.ba);
			check_count("sdram_addr on column command", addr_log[i + 1], a.col);
		end
	endtask

	// ------------------------------------------------------------------------
	// Directed tests
	// ------------------------------------------------------------------------
	task automatic test_init();
		integer n;
		check_cmd("pin command after reset", pin_cmd, NOP);
		check_count("sdram_ba after reset", sdram_ba, 2'h3);
		check_count("sdram_addr after reset", sdram_addr, 13'h1fff);
		check_dq("sdram_dq after reset", sdram_dq, 16'hzzzz);
		check_count("wr_burst_data_req after reset", wr_burst_data_req, 0);
		check_count("rd_burst_data_valid after reset", rd_burst_data_valid, 0);
		check_count("wr_burst_finish after reset", wr_burst_finish, 0);
		check_count("rd_burst_finish after reset", rd_burst_finish, 0);
		n = 0;
		while ((cmd_log.size() < 4) && (n < 25000))
		begin
			@(posedge clk);
			n = n + 1;
		end
		if (n >= 25000)
			abort_timeout("the init command sequence");
		else
		begin
			check_cmd("init command 1", cmd_log[0], PRE);
			check_cmd("init command 2", cmd_log[1], REF);
			check_cmd("init command 3", cmd_log[2], REF);
			check_cmd("init command 4", cmd_log[3], MRS);
			check_count("sdram_addr on MRS", addr_log[3], 13'h037);   // Full page, CL 3
		end
	endtask

	task automatic test_write_read();
		app_addr_t a;
		integer    len;
		a   = rand_addr();
		len = rand_len();
		run_write(a, len);
		run_read(a, len);
	endtask

	task automatic test_refresh();
		integer start;
		integer n;
		start = n_ref;
		n     = 0;
		while ((n_ref < start + 3) && (n < 3000))
		begin
			@(posedge clk);
			n = n + 1;
		end
		if (n >= 3000)
			abort_timeout("idle auto refresh");
		else
		begin
			@(posedge clk);
			check_count("REF spacing in cycles", ref_last - ref_prev, 751);
			start = n_ref;              // Now catch the next refresh
			n     = 0;
			while ((n_ref == start) && (n < 1000))
			begin
				@(posedge clk);
				n = n + 1;
			end
			if (n >= 1000)
				abort_timeout("a REF to collide with");
			else
				test_write_read();      // Raised during the refresh wait
		end
	endtask

	task automatic test_banks();
		app_addr_t a1;
		app_addr_t a2;
		integer    l1;
		integer    l2;
		a1     = rand_addr();
		a2     = a1;
		a2.ba  = a1.ba ^ 2'b01;     // Other bank, other row
		a2.row = a1.row ^ 13'h0a5a;
		l1     = rand_len();
		l2     = rand_len();
		check_access_write(a1, l1);
		check_access_write(a2, l2);
		check_access_read(a1, l1);
		check_access_read(a2, l2);
	endtask

	task automatic check_access_write(input app_addr_t a, input integer len);
		integer start;
		start = cmd_log.size();
		run_write(a, len);
		check_access(start, a, WRITE);
	endtask

	task automatic check_access_read(input app_addr_t a, input integer len);
		integer start;
		start = cmd_log.size();
		run_read(a, len);
		check_access(start, a, READ);
	endtask

	initial
	begin
		rst           = 1'b1;
		wr_burst_req  = 1'b0;
		wr_burst_data = '0;
		wr_burst_len  = 10'd1;
		wr_burst_addr = '0;
		rd_burst_req  = 1'b0;
		rd_burst_len  = 10'd1;
		rd_burst_addr = '0;
		repeat (3) @(posedge clk);
		rst <= 1'b0;
		@(posedge clk);
		test_init();
		test_write_read();
		test_refresh();
		test_banks();
		print_summary();
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- build.f
+incdir+source
source/sdram_pkg.sv
source/sdram_seq_if.sv
source/sdram_refresh_timer.sv
source/sdram_sequencer.sv
source/sdram_cmd_gen.sv
source/sdram_data_path.sv
source/sdram_ctrl_top.sv
bench/sdram_model.sv
bench/tb_sdram_ctrl.sv

//--- source/sdram_cmd_gen.sv
// Registered SDRAM command, bank and address pin drive from the sequencer state
`default_nettype none
`include "sdram_defs.svh"

module sdram_cmd_gen
(
	input  wire             clk,
	input  wire             rst,
	sdram_seq_if.cmd        seq,
	output logic            sdram_ras_n,
	output logic            sdram_cas_n,
	output logic            sdram_we_n,
	output sdram_pkg::ba_t  sdram_ba,
	output sdram_pkg::row_t sdram_addr
);
	import sdram_pkg::*;

	sdram_cmd_e cmd_nxt;
	sdram_cmd_e cmd_r;          // Command on the pins
	ba_t        ba_nxt;
	row_t       addr_nxt;

	// --------------------------------------------------------------------------
	// State to command decode
	// --------------------------------------------------------------------------
	always_comb
	begin
		cmd_nxt  = NOP;
		ba_nxt   = '1;              // Unused fields all ones
		addr_nxt = '1;
		case (seq.state)
			S_INIT_PRE, S_PRE:
				cmd_nxt = PRE;          // A10 high, all banks
			S_INIT_AR1, S_INIT_AR2, S_AR:
				cmd_nxt = REF;
			S_INIT_MRS:
			begin
				cmd_nxt  = MRS;
				ba_nxt   = '0;
				addr_nxt = `SDR_MODE_WORD;
			end
			S_ACTIVE:
			begin
				cmd_nxt  = ACT;
				ba_nxt   = seq.acc_addr.ba;
				addr_nxt = seq.acc_addr.row;
			end
			S_READ:
			begin
				cmd_nxt  = READ;
				ba_nxt   = seq.acc_addr.ba;
				addr_nxt = {{(`SDR_ROW_W - `SDR_COL_W){1'b0}}, seq.acc_addr.col};  // A10 low
			end
			S_WRITE:
			begin
				cmd_nxt  = WRITE;
				ba_nxt   = seq.acc_addr.ba;
				addr_nxt = {{(`SDR_ROW_W - `SDR_COL_W){1'b0}}, seq.acc_addr.col};
			end
			S_RD, S_WD:
			begin
				if (seq.burst_last)
					cmd_nxt = BST;      // Ends the full-page burst
			end
			default:
				cmd_nxt = NOP;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			cmd_r      <= NOP;
			sdram_ba   <= '1;
			sdram_addr <= '1;
		end
		else
		begin
			cmd_r      <= cmd_nxt;      // Pins trail state by one cycle
			sdram_ba   <= ba_nxt;
			sdram_addr <= addr_nxt;
		end
	end

	assign {sdram_ras_n, sdram_cas_n, sdram_we_n} = cmd_r;

endmodule

`default_nettype wire

//--- source/sdram_ctrl_top.sv
// SDR SDRAM controller top level joining the user burst ports to the device pins
`default_nettype none
`include "sdram_defs.svh"

module sdram_ctrl_top
(
	input  wire                        clk,
	input  wire                        rst,
	// Write port
	input  wire                        wr_burst_req,
	input  wire sdram_pkg::dq_t        wr_burst_data,
	input  wire sdram_pkg::burst_len_t wr_burst_len,
	input  wire sdram_pkg::app_addr_t  wr_burst_addr,
	output wire                        wr_burst_data_req,
	output wire                        wr_burst_finish,
	// Read port
	input  wire                        rd_burst_req,
	input  wire sdram_pkg::burst_len_t rd_burst_len,
	input  wire sdram_pkg::app_addr_t  rd_burst_addr,
	output wire sdram_pkg::dq_t        rd_burst_data,
	output wire                        rd_burst_data_valid,
	output wire                        rd_burst_finish,
	// SDRAM device
	output wire                        sdram_cke,
	output wire                        sdram_cs_n,
	output wire                        sdram_ras_n,
	output wire                        sdram_cas_n,
	output wire                        sdram_we_n,
	output wire sdram_pkg::ba_t        sdram_ba,
	output wire sdram_pkg::row_t       sdram_addr,
	output wire [`SDR_DQ_W/8-1:0]      sdram_dqm,
	inout  wire sdram_pkg::dq_t        sdram_dq
);

	wire init_go;               // Power-up wait done
	wire ref_req;               // Refresh pending
	wire ref_ack;               // Refresh issued

	sdram_seq_if u_seq_if ();

	sdram_refresh_timer u_refresh_timer (
		.clk     (clk),
		.rst     (rst),
		.ref_ack (ref_ack),
		.init_go (init_go),
		.ref_req (ref_req)
	);

	sdram_sequencer u_sequencer (
		.clk               (clk),
		.rst               (rst),
		.init_go           (init_go),
		.ref_req           (ref_req),
		.wr_burst_req      (wr_burst_req),
		.rd_burst_req      (rd_burst_req),
		.wr_burst_len      (wr_burst_len),
		.rd_burst_len      (rd_burst_len),
		.wr_burst_addr     (wr_burst_addr),
		.rd_burst_addr     (rd_burst_addr),
		.ref_ack           (ref_ack),
		.wr_burst_data_req (wr_burst_data_req),
		.wr_burst_finish   (wr_burst_finish),
		.seq               (u_seq_if.seq)
	);

	sdram_cmd_gen u_cmd_gen (
		.clk         (clk),
		.rst         (rst),
		.seq         (u_seq_if.cmd),
		.sdram_ras_n (sdram_ras_n),
		.sdram_cas_n (sdram_cas_n),
		.sdram_we_n  (sdram_we_n),
		.sdram_ba    (sdram_ba),
		.sdram_addr  (sdram_addr)
	);

	sdram_data_path u_data_path (
		.clk                 (clk),
		.rst                 (rst),
		.seq                 (u_seq_if.dp),
		.wr_burst_data_req   (wr_burst_data_req),
		.wr_burst_data       (wr_burst_data),
		.sdram_dq            (sdram_dq),
		.rd_burst_len        (rd_burst_len),
		.rd_burst_data       (rd_burst_data),
		.rd_burst_data_valid (rd_burst_data_valid),
		.rd_burst_finish     (rd_burst_finish)
	);

	assign sdram_cke  = 1'b1;   // Clock always enabled
	assign sdram_cs_n = 1'b0;   // Single device, always selected
	assign sdram_dqm  = '0;     // No byte masking

endmodule

`default_nettype wire

//--- source/sdram_data_path.sv
// SDRAM data bus tristate, write data register, read capture and burst strobes
`default_nettype none
`include "sdram_defs.svh"

module sdram_data_path
(
	input  wire                        clk,
	input  wire                        rst,
	sdram_seq_if.dp                    seq,
	input  wire                        wr_burst_data_req,
	input  wire sdram_pkg::dq_t        wr_burst_data,
	inout  wire sdram_pkg::dq_t        sdram_dq,
	input  wire sdram_pkg::burst_len_t rd_burst_len,
	output sdram_pkg::dq_t             rd_burst_data,
	output logic                       rd_burst_data_valid,
	output logic                       rd_burst_finish
);
	import sdram_pkg::*;

	logic wr_req_d;             // Request delayed to the data cycle
	logic dq_oe;                // Drive enable for DQ
	dq_t  dq_out;               // Write word on the bus
	logic valid_d;              // Delayed read valid

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			wr_req_d <= 1'b0;
			dq_oe    <= 1'b0;       // Bus released
			valid_d  <= 1'b0;
		end
		else
		begin
			wr_req_d <= wr_burst_data_req;
			dq_oe    <= wr_req_d;   // Aligned with dq_out
			valid_d  <= rd_burst_data_valid;
		end
	end

	always_ff @(posedge clk)
	begin
		if (wr_req_d)
			dq_out <= wr_burst_data;    // User word arrives after request
	end

	assign sdram_dq = dq_oe ? dq_out : 'z;

	// --------------------------------------------------------------------------
	// Read side
	// --------------------------------------------------------------------------
	always_ff @(posedge clk)
	begin
		if (seq.state == S_RD)
			rd_burst_data <= sdram_dq;  // One word per cycle
	end

	// Captured word lags DQ by one, so beats sit at counts 1 to len
	assign rd_burst_data_valid = seq.read_flag && (seq.state == S_RD)
		&& (seq.cnt != '0) && (seq.cnt <= rd_burst_len);

	assign rd_burst_finish = valid_d && !rd_burst_data_valid;   // Falling edge

endmodule

`default_nettype wire

//--- source/sdram_defs.svh
// SDR SDRAM controller constants for device timing, field widths and mode word
`ifndef SDRAM_DEFS_SVH
`define SDRAM_DEFS_SVH

// --------------------------------------------------------------------------
// Device timing in clock cycles
// --------------------------------------------------------------------------
`define SDR_T_RP         4          // Precharge period
`define SDR_T_RC         6          // Refresh to refresh or activate
`define SDR_T_MRD        6          // Mode register set to next command
`define SDR_T_RCD        2          // Activate to read or write
`define SDR_T_WR         3          // Write recovery before precharge
`define SDR_CAS_LAT      3          // CAS latency

`define SDR_POWERUP_CYC  20000      // Power-up stable wait, 200 us at 100 MHz
`define SDR_REFRESH_CYC  750        // Refresh counter wrap value, 7.5 us

// --------------------------------------------------------------------------
// Field widths
// --------------------------------------------------------------------------
`define SDR_BA_W         2          // 4 banks
`define SDR_ROW_W        13         // 8192 rows
`define SDR_COL_W        9          // 512 columns
`define SDR_DQ_W         16         // x16 data bus
`define SDR_LEN_W        10         // Burst length, up to 512 words
`define SDR_CNT_W        15         // Power-up counter

// Sequential, full page, CAS latency 3, burst write enabled
`define SDR_MODE_WORD    13'h037

`endif

//--- source/sdram_pkg.sv
// Shared types for the SDRAM controller states, pin commands and address fields
`default_nettype none
`include "sdram_defs.svh"

package sdram_pkg;

	typedef enum logic [4:0] {
		S_INIT_NOP,     // Power-up wait
		S_INIT_PRE,     // Init precharge all
		S_INIT_TRP,     // Init precharge wait
		S_INIT_AR1,     // First init refresh
		S_INIT_TRF1,    // First refresh wait
		S_INIT_AR2,     // Second init refresh
		S_INIT_TRF2,    // Second refresh wait
		S_INIT_MRS,     // Mode register set
		S_INIT_TMRD,    // Mode register wait
		S_INIT_DONE,    // Init complete
		S_IDLE,         // Waiting for refresh or access
		S_ACTIVE,       // Row activate
		S_TRCD,         // Activate to column wait
		S_READ,         // Read command
		S_CL,           // CAS latency wait
		S_RD,           // Read burst
		S_WRITE,        // Write command
		S_WD,           // Write burst
		S_TWR,          // Write recovery
		S_PRE,          // Precharge after access
		S_TRP,          // Precharge wait
		S_AR,           // Periodic auto refresh
		S_TRFC          // Refresh wait
	} sdram_state_e;

	// {ras_n, cas_n, we_n}
	typedef enum logic [2:0] {
		NOP   = 3'b111,
		ACT   = 3'b011,
		READ  = 3'b101,
		WRITE = 3'b100,
		BST   = 3'b110,
		PRE   = 3'b010,
		REF   = 3'b001,
		MRS   = 3'b000
	} sdram_cmd_e;

	typedef logic [`SDR_BA_W-1:0]  ba_t;
	typedef logic [`SDR_ROW_W-1:0] row_t;
	typedef logic [`SDR_COL_W-1:0] col_t;
	typedef logic [`SDR_DQ_W-1:0]  dq_t;
	typedef logic [`SDR_LEN_W-1:0] burst_len_t;
	typedef logic [`SDR_LEN_W-1:0] cyc_cnt_t;

	typedef struct packed {
		ba_t  ba;       // Bank, top bits
		row_t row;
		col_t col;      // Column, low bits
	} app_addr_t;

endpackage

`default_nettype wire

//--- source/sdram_refresh_timer.sv
// Power-up wait counter and periodic auto-refresh request for the SDRAM controller
`default_nettype none
`include "sdram_defs.svh"

module sdram_refresh_timer
(
	input  wire  clk,
	input  wire  rst,
	input  wire  ref_ack,       // Pulse from sequencer in refresh issue
	output logic init_go,       // Power-up wait elapsed
	output logic ref_req        // Refresh pending
);
	import sdram_pkg::*;

	logic [`SDR_CNT_W-1:0] pwr_cnt;     // Saturating power-up counter
	cyc_cnt_t              ref_cnt;     // Free-running refresh interval

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			pwr_cnt <= '0;
		else if (pwr_cnt < `SDR_POWERUP_CYC)
			pwr_cnt <= pwr_cnt + 1'b1;  // Holds once reached
	end

	assign init_go = (pwr_cnt == `SDR_POWERUP_CYC);   // Stays high after power-up

	// --------------------------------------------------------------------------
	// Refresh interval, 751 cycles per wrap
	// --------------------------------------------------------------------------
	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			ref_cnt <= '0;
		else if (ref_cnt < `SDR_REFRESH_CYC)
			ref_cnt <= ref_cnt + 1'b1;
		else
			ref_cnt <= '0;              // Wrap
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			ref_req <= 1'b0;
		else if (ref_cnt == `SDR_REFRESH_CYC - 1)
			ref_req <= 1'b1;            // New interval wins over ack
		else if (ref_ack)
			ref_req <= 1'b0;
	end

endmodule

`default_nettype wire

//--- source/sdram_seq_if.sv
// Sequencer state, counter and access fields shared with the command and data blocks
`default_nettype none

interface sdram_seq_if;
	import sdram_pkg::*;

	sdram_state_e state;        // Current controller state
	cyc_cnt_t     cnt;          // Shared wait and burst counter
	logic         read_flag;    // Latched direction, high for read
	logic         burst_last;   // Last beat of read or write burst
	app_addr_t    acc_addr;     // Address latched in idle

	modport seq (
		output state,
		output cnt,
		output read_flag,
		output burst_last,
		output acc_addr
	);

	modport cmd (
		input state,
		input burst_last,
		input acc_addr
	);

	modport dp (
		input state,
		input cnt,
		input read_flag
	);

endinterface

`default_nettype wire

//--- source/sdram_sequencer.sv
// Main SDRAM controller state machine covering init, refresh and full-page bursts
`default_nettype none
`include "sdram_defs.svh"

module sdram_sequencer
(
	input  wire                        clk,
	input  wire                        rst,
	input  wire                        init_go,
	input  wire                        ref_req,
	input  wire                        wr_burst_req,
	input  wire                        rd_burst_req,
	input  wire sdram_pkg::burst_len_t wr_burst_len,
	input  wire sdram_pkg::burst_len_t rd_burst_len,
	input  wire sdram_pkg::app_addr_t  wr_burst_addr,
	input  wire sdram_pkg::app_addr_t  rd_burst_addr,
	output logic                       ref_ack,
	output logic                       wr_burst_data_req,
	output logic                       wr_burst_finish,
	sdram_seq_if.seq                   seq
);
	import sdram_pkg::*;

	sdram_state_e state;
	sdram_state_e state_nxt;
	cyc_cnt_t     cnt;          // Shared wait and burst counter
	logic         counting;     // State uses the counter
	logic         wait_done;    // Last cycle of the current wait
	logic         access_go;    // Idle accepts a user request
	logic         read_flag;
	app_addr_t    acc_addr;
	burst_len_t   acc_len;      // Length of the active direction
	logic         burst_last;

	assign access_go = (state == S_IDLE) && !ref_req && (wr_burst_req || rd_burst_req);
	assign acc_len   = read_flag ? rd_burst_len : wr_burst_len;

	assign burst_last = ((state == S_RD) || (state == S_WD)) && (cnt == acc_len - 1'b1);

	// --------------------------------------------------------------------------
	// Wait length per state
	// --------------------------------------------------------------------------
	always_comb
	begin
		counting  = 1'b1;
		wait_done = 1'b0;
		case (state)
			S_INIT_TRP, S_TRP:                  wait_done = (cnt == `SDR_T_RP - 1);
			S_INIT_TRF1, S_INIT_TRF2, S_TRFC:   wait_done = (cnt == `SDR_T_RC - 1);
			S_INIT_TMRD:                        wait_done = (cnt == `SDR_T_MRD - 1);
			S_TRCD:                             wait_done = (cnt == `SDR_T_RCD - 1);
			S_CL:                               wait_done = (cnt == `SDR_CAS_LAT - 1);
			S_WD:                               wait_done = burst_last;
			S_RD:                               wait_done = (cnt == rd_burst_len + 2'd2);
			S_TWR:                              wait_done = (cnt == `SDR_T_WR - 1);
			default:                            counting  = 1'b0;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
			cnt <= '0;
		else if (counting && !wait_done)
			cnt <= cnt + 1'b1;
		else
			cnt <= '0;                  // Zero on entry to every wait
	end

	// --------------------------------------------------------------------------
	// Next state
	// --------------------------------------------------------------------------
	always_comb
	begin
		state_nxt = state;
		case (state)
			S_INIT_NOP:  if (init_go) state_nxt = S_INIT_PRE;
			S_INIT_PRE:  state_nxt = S_INIT_TRP;
			S_INIT_TRP:  if (wait_done) state_nxt = S_INIT_AR1;
			S_INIT_AR1:  state_nxt = S_INIT_TRF1;
			S_INIT_TRF1: if (wait_done) state_nxt = S_INIT_AR2;
			S_INIT_AR2:  state_nxt = S_INIT_TRF2;
			S_INIT_TRF2: if (wait_done) state_nxt = S_INIT_MRS;
			S_INIT_MRS:  state_nxt = S_INIT_TMRD;
			S_INIT_TMRD: if (wait_done) state_nxt = S_INIT_DONE;
			S_INIT_DONE: state_nxt = S_IDLE;
			S_IDLE:
			begin
				if (ref_req)
					state_nxt = S_AR;       // Refresh first
				else if (access_go)
					state_nxt = S_ACTIVE;
			end
			S_ACTIVE:    state_nxt = S_TRCD;
			S_TRCD:      if (wait_done) state_nxt = read_flag ? S_READ : S_WRITE;
			S_READ:      state_nxt = S_CL;
			S_CL:        if (wait_done) state_nxt = S_RD;
			S_RD:        if (wait_done) state_nxt = S_PRE;
			S_WRITE:     state_nxt = S_WD;
			S_WD:        if (wait_done) state_nxt = S_TWR;
			S_TWR:       if (wait_done) state_nxt = S_PRE;
			S_PRE:       state_nxt = S_TRP;
			S_TRP:       if (wait_done) state_nxt = S_IDLE;
			S_AR:        state_nxt = S_TRFC;
			S_TRFC:      if (wait_done) state_nxt = S_IDLE;
			default:     state_nxt = S_INIT_NOP;
		endcase
	end

	always_ff @(posedge clk or posedge rst)
	begin
		if (rst)
		begin
			state     <= S_INIT_NOP;
			read_flag <= 1'b0;
		end
		else
		begin
			state <= state_nxt;
			if (access_go)
				read_flag <= !wr_burst_req;     // Write wins over read
		end
	end

	always_ff @(posedge clk)
	begin
		if (access_go)
			acc_addr <= wr_burst_req ? wr_burst_addr : rd_burst_addr;
	end

	// Request runs one cycle ahead of the registered write data
	assign wr_burst_data_req = ((state == S_TRCD) && wait_done && !read_flag)
		|| ((state == S_WRITE) && (wr_burst_len > 1))
		|| ((state == S_WD) && ((cnt + 2) < wr_burst_len));

	assign wr_burst_finish = (state == S_WD) && burst_last;
	assign ref_ack         = (state == S_AR);

	assign seq.state      = state;
	assign seq.cnt        = cnt;
	assign seq.read_flag  = read_flag;
	assign seq.burst_last = burst_last;
	assign seq.acc_addr   = acc_addr;

endmodule

`default_nettype wire
